//--- hdl/mm_bus_pkg.sv
`default_nettype none

package mm_bus_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int BYTES_PER_WORD = DATA_WIDTH / 8;
  localparam int OFFSET_WIDTH   = 2;
  localparam int ADDR_WIDTH     = 32;

  typedef logic [ADDR_WIDTH-1:0]     mm_addr_t;
  typedef logic [DATA_WIDTH-1:0]     mm_data_t;
  typedef logic [BYTES_PER_WORD-1:0] mm_be_t;
  typedef logic [OFFSET_WIDTH-1:0]   byte_offset_t;

  // One write request on the memory-mapped bus.
  typedef struct packed {
    mm_addr_t address;
    mm_data_t writedata;
    mm_be_t   byteenable;
    logic     write;
  } mm_write_t;

endpackage

`default_nettype wire

//--- hdl/dma_cmd_pkg.sv
`default_nettype none

package dma_cmd_pkg;

  localparam int LENGTH_WIDTH    = 16;
  localparam int FIFO_DEPTH      = 16;
  localparam int FIFO_ADDR_WIDTH = 4;

  typedef logic [LENGTH_WIDTH-1:0]  length_t;
  typedef logic [FIFO_ADDR_WIDTH:0] fifo_count_t;

  // Byte address and byte length of one transfer.
  typedef struct packed {
    mm_bus_pkg::mm_addr_t address;
    length_t              length;
  } write_cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    START,
    WRITE,
    DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/stream_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module stream_fifo (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  push,
  input  mm_bus_pkg::mm_data_t push_data,
  input  wire                  pop,
  output mm_bus_pkg::mm_data_t head_data,
  output logic                 empty,
  output logic                 full
);
  import mm_bus_pkg::*;
  import dma_cmd_pkg::*;

  mm_data_t                   mem [FIFO_DEPTH];
  logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
  logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
  fifo_count_t                count;
  logic                       do_push;
  logic                       do_pop;

  // Overflowing pushes and underflowing pops are dropped.
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  assign head_data = mem[rd_ptr];
  assign empty     = (count == '0);
  assign full      = (count == fifo_count_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- hdl/st_to_mm_adapter.sv
`timescale 1ns/1ns
`default_nettype none

module st_to_mm_adapter (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      enable,
  input  wire                      start,
  input  mm_bus_pkg::byte_offset_t offset,
  input  wire                      drain,
  input  wire                      waitrequest,
  input  mm_bus_pkg::mm_data_t     fifo_data,
  input  wire                      fifo_empty,
  output mm_bus_pkg::mm_data_t     write_data,
  output logic                     data_ready,
  output logic                     beat_taken,
  output logic                     fifo_readack
);
  import mm_bus_pkg::*;

  byte_offset_t              offset_q;
  mm_data_t                  remainder;
  logic [2*DATA_WIDTH-1:0]   shifted_wide;
  mm_data_t                  shifted_low;
  mm_data_t                  shifted_high;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      offset_q <= '0;
    end
    else if (start)
    begin
      offset_q <= offset;
    end
  end

  // Low half lands in this beat, high half is carried to the next.
  assign shifted_wide = {{DATA_WIDTH{1'b0}}, fifo_data} << (8 * offset_q);
  assign shifted_low  = shifted_wide[DATA_WIDTH-1:0];
  assign shifted_high = shifted_wide[2*DATA_WIDTH-1:DATA_WIDTH];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      remainder <= '0;
    end
    else if (start)
    begin
      remainder <= '0;
    end
    else if (fifo_readack)
    begin
      remainder <= shifted_high;
    end
  end

  // A drain beat carries only the leftover bytes; the FIFO head is stale.
  assign write_data = drain ? remainder : (shifted_low | remainder);

  assign data_ready   = enable & (~fifo_empty | drain);
  assign beat_taken   = data_ready & ~waitrequest & ~start;
  assign fifo_readack = beat_taken & ~drain;

endmodule

`default_nettype wire

//--- hdl/write_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module write_ctrl (
  input  wire                      clk,
  input  wire                      reset,
  input  dma_cmd_pkg::write_cmd_t  cmd,
  input  wire                      cmd_valid,
  input  wire                      data_ready,
  input  wire                      beat_taken,
  output logic                     realign_start,
  output mm_bus_pkg::byte_offset_t realign_offset,
  output logic                     xfer_enable,
  output logic                     drain,
  output mm_bus_pkg::mm_addr_t     mm_address,
  output mm_bus_pkg::mm_be_t       mm_byteenable,
  output logic                     mm_write,
  output logic                     busy,
  output logic                     done
);
  import mm_bus_pkg::*;
  import dma_cmd_pkg::*;

  ctrl_state_t             state;
  logic                    accept;
  byte_offset_t            cmd_offset;
  logic [LENGTH_WIDTH:0]   end_sum;
  logic [LENGTH_WIDTH:0]   beats_calc;
  logic [LENGTH_WIDTH:0]   words_calc;
  mm_addr_t                addr_q;
  byte_offset_t            offset_q;
  byte_offset_t            end_lane_q;
  length_t                 beats_left;
  logic                    drain_pending;
  logic                    first_beat;
  logic                    last_beat;
  mm_be_t                  first_be;
  mm_be_t                  last_be;

  assign busy   = (state == START) || (state == WRITE);
  assign done   = (state == DONE);
  assign accept = cmd_valid & ~busy;

  // Beat and word counts, rounded up to whole words.
  assign cmd_offset = cmd.address[OFFSET_WIDTH-1:0];
  assign end_sum    = {1'b0, cmd.length} + (LENGTH_WIDTH+1)'(cmd_offset);
  assign beats_calc = (end_sum + (LENGTH_WIDTH+1)'(BYTES_PER_WORD - 1)) >> OFFSET_WIDTH;
  assign words_calc = ({1'b0, cmd.length} + (LENGTH_WIDTH+1)'(BYTES_PER_WORD - 1))
                      >> OFFSET_WIDTH;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state         <= IDLE;
      addr_q        <= '0;
      offset_q      <= '0;
      end_lane_q    <= '0;
      beats_left    <= '0;
      drain_pending <= 1'b0;
      first_beat    <= 1'b0;
    end
    else if (accept)
    begin
      state         <= START;
      addr_q        <= {cmd.address[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
      offset_q      <= cmd_offset;
      end_lane_q    <= end_sum[OFFSET_WIDTH-1:0];
      beats_left    <= beats_calc[LENGTH_WIDTH-1:0];
      drain_pending <= (beats_calc > words_calc);
      first_beat    <= 1'b1;
    end
    else
    begin
      case (state)
        START: state <= WRITE;
        WRITE:
        begin
          if (beat_taken)
          begin
            addr_q     <= addr_q + mm_addr_t'(BYTES_PER_WORD);
            beats_left <= beats_left - 1'b1;
            first_beat <= 1'b0;
            if (last_beat)
              state <= DONE;
          end
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign last_beat      = (beats_left == length_t'(1));
  assign realign_start  = (state == START);
  assign realign_offset = offset_q;
  assign xfer_enable    = (state == WRITE);
  assign drain          = xfer_enable & last_beat & drain_pending;

  // Lanes at or above the start offset, and below the end lane.
  assign first_be = '1 << offset_q;
  assign last_be  = (end_lane_q == '0) ? '1 : ~(mm_be_t'('1) << end_lane_q);

  assign mm_byteenable = (first_beat ? first_be : '1) & (last_beat ? last_be : '1);
  assign mm_address    = addr_q;
  assign mm_write      = xfer_enable & data_ready;

endmodule

`default_nettype wire

//--- hdl/write_master.sv
`timescale 1ns/1ns
`default_nettype none

module write_master (
  input  wire                     clk,
  input  wire                     reset,
  input  dma_cmd_pkg::write_cmd_t cmd,
  input  wire                     cmd_valid,
  output logic                    busy,
  output logic                    done,
  input  mm_bus_pkg::mm_data_t    st_data,
  input  wire                     st_valid,
  output logic                    fifo_full,
  output mm_bus_pkg::mm_write_t   mm,
  input  wire                     mm_waitrequest
);
  import mm_bus_pkg::*;

  mm_data_t     fifo_data;
  logic         fifo_empty;
  logic         fifo_pop;
  logic         realign_start;
  byte_offset_t realign_offset;
  logic         xfer_enable;
  logic         drain;
  logic         data_ready;
  logic         beat_taken;
  mm_data_t     write_data;
  mm_addr_t     ctrl_address;
  mm_be_t       ctrl_byteenable;
  logic         ctrl_write;

  stream_fifo u_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (st_valid),
    .push_data (st_data),
    .pop       (fifo_pop),
    .head_data (fifo_data),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

  st_to_mm_adapter u_adapter (
    .clk          (clk),
    .reset        (reset),
    .enable       (xfer_enable),
    .start        (realign_start),
    .offset       (realign_offset),
    .drain        (drain),
    .waitrequest  (mm_waitrequest),
    .fifo_data    (fifo_data),
    .fifo_empty   (fifo_empty),
    .write_data   (write_data),
    .data_ready   (data_ready),
    .beat_taken   (beat_taken),
    .fifo_readack (fifo_pop)
  );

  write_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .data_ready     (data_ready),
    .beat_taken     (beat_taken),
    .realign_start  (realign_start),
    .realign_offset (realign_offset),
    .xfer_enable    (xfer_enable),
    .drain          (drain),
    .mm_address     (ctrl_address),
    .mm_byteenable  (ctrl_byteenable),
    .mm_write       (ctrl_write),
    .busy           (busy),
    .done           (done)
  );

  // Bus request from controller fields and adapter data.
  assign mm.address    = ctrl_address;
  assign mm.writedata  = write_data;
  assign mm.byteenable = ctrl_byteenable;
  assign mm.write      = ctrl_write;

endmodule

`default_nettype wire

//--- sim/write_checker.sv
`timescale 1ns/1ns
`default_nettype none

module write_checker (
  input  wire                   clk,
  input  wire                   reset,
  input  mm_bus_pkg::mm_write_t mm,
  input  wire                   mm_waitrequest,
  input  wire                   busy,
  input  wire                   done,
  input  wire                   st_valid,
  input  wire                   fifo_full
);
  import mm_bus_pkg::*;
  import dma_cmd_pkg::*;

  localparam int MAX_BYTES = 128;

  string      cur_name;
  mm_addr_t   cur_addr;
  int         cur_len;
  int         cur_words;
  int         exp_beats;
  logic       active;
  int         beat_count;
  int         errors;
  logic [7:0] image [MAX_BYTES];
  logic       written [MAX_BYTES];
  int         pass_count;
  int         fail_count;
  int         fifo_level;
  logic       exp_full;

  initial
  begin
    active     = 1'b0;
    pass_count = 0;
    fail_count = 0;
    fifo_level = 0;
  end

  task automatic check_idle();
    if (busy || done || mm.write)
    begin
      $display("MISMATCH reset_idle expected 000 actual %b%b%b", busy, done, mm.write);
      fail_count++;
    end
    else
    begin
      $display("reset_idle: passed");
      pass_count++;
    end
  endtask

  task automatic begin_test(input string name, input mm_addr_t addr, input int len);
    cur_name   = name;
    cur_addr   = addr;
    cur_len    = len;
    cur_words  = (len + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
    // Beats cover the offset plus the length, rounded up to words.
    exp_beats  = (int'(addr[OFFSET_WIDTH-1:0]) + len + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
    beat_count = 0;
    errors     = 0;
    for (int i = 0; i < MAX_BYTES; i++)
      written[i] = 1'b0;
    active = 1'b1;
  endtask

  task automatic set_byte(input int idx, input logic [7:0] value);
    image[idx] = value;
  endtask

  task automatic check_beat();
    mm_addr_t exp_addr;
    mm_addr_t lane_addr;
    mm_be_t   exp_be;
    int       rel;
    exp_addr = (cur_addr & ~mm_addr_t'(BYTES_PER_WORD - 1))
               + mm_addr_t'(BYTES_PER_WORD * beat_count);
    if (beat_count >= exp_beats)
    begin
      $display("%s: extra beat at address %h after %0d beats", cur_name, mm.address,
               exp_beats);
      errors++;
    end
    else
    begin
      if (mm.address !== exp_addr)
      begin
        $display("MISMATCH %s address expected %h actual %h", cur_name, exp_addr, mm.address);
        errors++;
      end
      for (int lane = 0; lane < BYTES_PER_WORD; lane++)
      begin
        lane_addr    = exp_addr + mm_addr_t'(lane);
        exp_be[lane] = (lane_addr >= cur_addr) && (lane_addr < cur_addr + mm_addr_t'(cur_len));
      end
      if (mm.byteenable !== exp_be)
      begin
        $display("MISMATCH %s byteenable expected %b actual %b", cur_name, exp_be,
                 mm.byteenable);
        errors++;
      end
      for (int lane = 0; lane < BYTES_PER_WORD; lane++)
      begin
        if (exp_be[lane] && mm.byteenable[lane])
        begin
          rel = int'(exp_addr + mm_addr_t'(lane) - cur_addr);
          if (mm.writedata[8*lane +: 8] !== image[rel])
          begin
            $display("MISMATCH %s byte %0d expected %h actual %h", cur_name, rel, image[rel],
                     mm.writedata[8*lane +: 8]);
            errors++;
          end
          written[rel] = 1'b1;
        end
      end
    end
    beat_count++;
  endtask

  task automatic finish_test();
    if (beat_count < exp_beats)
    begin
      $display("%s: only %0d of %0d beats were written", cur_name, beat_count, exp_beats);
      errors++;
    end
    for (int i = 0; i < cur_len; i++)
    begin
      if (!written[i])
      begin
        $display("%s: byte %0d of the transfer was never written", cur_name, i);
        errors++;
      end
    end
    if (errors == 0)
    begin
      $display("%s: %0d beats, passed", cur_name, beat_count);
      pass_count++;
    end
    else
    begin
      $display("%s: failed with %0d errors", cur_name, errors);
      fail_count++;
    end
    active = 1'b0;
  endtask

  // A beat counts only on the cycle the bus accepts it.
  always @(posedge clk)
  begin
    if (reset)
      fifo_level = 0;
    else
    begin
      // Stream FIFO occupancy, fed by pushes and drained by non-drain beats.
      exp_full = (fifo_level == FIFO_DEPTH);
      if (fifo_full !== exp_full)
      begin
        $display("MISMATCH %s fifo_full expected %b actual %b", cur_name, exp_full,
                 fifo_full);
        if (active)
          errors++;
        else
          fail_count++;
      end
      if (st_valid && fifo_level < FIFO_DEPTH)
        fifo_level++;
      if (mm.write && !mm_waitrequest && active && beat_count < cur_words)
        fifo_level--;
      if (mm.write && !mm_waitrequest)
      begin
        if (active)
          check_beat();
        else
        begin
          $display("Bus write accepted at %h with no transfer in progress", mm.address);
          fail_count++;
        end
      end
      if (done)
      begin
        if (active)
          finish_test();
        else
        begin
          $display("Done pulsed with no transfer in progress");
          fail_count++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_write_master.sv
`timescale 1ns/1ns
`default_nettype none

module tb_write_master;
  import mm_bus_pkg::*;
  import dma_cmd_pkg::*;

  localparam int NUM_TESTS = 9;
  localparam int MAX_WORDS = 32;

  logic        clk;
  logic        reset;
  write_cmd_t  cmd;
  logic        cmd_valid;
  logic        busy;
  logic        done;
  mm_data_t    st_data;
  logic        st_valid;
  logic        fifo_full;
  mm_write_t   mm;
  logic        mm_waitrequest;

  string       test_name [NUM_TESTS];
  mm_addr_t    test_addr [NUM_TESTS];
  int          test_len [NUM_TESTS];
  int          test_density [NUM_TESTS];
  mm_data_t    words [MAX_WORDS];
  logic [31:0] rand_state;
  int          cycle_count;
  int          cycle_limit;

  write_master u_write_master (
    .clk            (clk),
    .reset          (reset),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .busy           (busy),
    .done           (done),
    .st_data        (st_data),
    .st_valid       (st_valid),
    .fifo_full      (fifo_full),
    .mm             (mm),
    .mm_waitrequest (mm_waitrequest)
  );

  write_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .mm             (mm),
    .mm_waitrequest (mm_waitrequest),
    .busy           (busy),
    .done           (done),
    .st_valid       (st_valid),
    .fifo_full      (fifo_full)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Run timed out after %0d cycles before all tests finished", cycle_count);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_test(input int idx, input string name, input mm_addr_t addr,
                          input int len, input int density);
    test_name[idx]    = name;
    test_addr[idx]    = addr;
    test_len[idx]     = len;
    test_density[idx] = density;
  endtask

  task automatic push_words(input int n_words);
    int k;
    k = 0;
    while (k < n_words)
    begin
      if (!fifo_full)
      begin
        st_valid = 1'b1;
        st_data  = words[k];
        k++;
      end
      else
        st_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    st_valid = 1'b0;
  endtask

  // Density is the wait request probability in percent.
  task automatic drive_waitrequest(input int density);
    do
    begin
      rand_state     = lcg_next(rand_state);
      mm_waitrequest = (int'(rand_state[31:16]) % 100) < density;
      @(posedge clk);
      #1;
    end
    while (!done);
    mm_waitrequest = 1'b0;
  endtask

  task automatic run_test(input int t);
    int n_words;
    n_words = (test_len[t] + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
    @(posedge clk);
    #1;
    u_checker.begin_test(test_name[t], test_addr[t], test_len[t]);
    for (int k = 0; k < n_words; k++)
    begin
      rand_state = lcg_next(rand_state);
      words[k]   = rand_state;
    end
    // Stream byte i is lane i mod 4 of word i / 4.
    for (int k = 0; k < test_len[t]; k++)
      u_checker.set_byte(k, words[k / 4][8*(k % 4) +: 8]);
    cmd.address = test_addr[t];
    cmd.length  = length_t'(test_len[t]);
    cmd_valid   = 1'b1;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    fork
      push_words(n_words);
      drive_waitrequest(test_density[t]);
    join
  endtask

  initial
  begin
    int total_words;
    cmd            = '0;
    cmd_valid      = 1'b0;
    st_data        = '0;
    st_valid       = 1'b0;
    mm_waitrequest = 1'b0;
    reset          = 1'b1;
    rand_state     = 32'hd7acae7b;
    cycle_count    = 0;
    cycle_limit    = 1000;
    add_test(0, "aligned_16", 32'h0000_1000, 16, 0);
    add_test(1, "unaligned_drain", 32'h0000_2003, 10, 0);
    add_test(2, "short_inside", 32'h0000_3001, 2, 0);
    add_test(3, "heavy_wait", 32'h0000_2003, 10, 80);
    add_test(4, "long_offset2", 32'h0000_4002, 70, 30);
    add_test(5, "b2b_offset1", 32'h0000_5001, 7, 0);
    add_test(6, "b2b_offset3", 32'h0000_6007, 5, 0);
    add_test(7, "b2b_aligned", 32'h0000_7000, 9, 10);
    add_test(8, "fifo_fill", 32'h0000_8001, 100, 90);
    total_words = 0;
    for (int t = 0; t < NUM_TESTS; t++)
      total_words += (test_len[t] + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
    cycle_limit = 200 * NUM_TESTS + 40 * total_words;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;
    u_checker.check_idle();
    for (int t = 0; t < NUM_TESTS; t++)
      run_test(t);
    @(posedge clk);
    #1;
    $display("Tests passed: %0d, failed: %0d", u_checker.pass_count, u_checker.fail_count);
    if (u_checker.fail_count == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hdl/mm_bus_pkg.sv
hdl/dma_cmd_pkg.sv
hdl/stream_fifo.sv
hdl/st_to_mm_adapter.sv
hdl/write_ctrl.sv
hdl/write_master.sv
sim/write_checker.sv
sim/tb_write_master.sv

//--- Makefile
TOP = tb_write_master

all: run

compile:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
